/* Makefile */
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= cacheTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/cacheTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module cacheTb;
  import cacheAddrPkg::*;
  import cacheDataPkg::*;

  localparam int numDisabled = 8;
  localparam int numRandom   = 32;
  // disabled, hits, replacement, random, invalidate, counter clear
  localparam int numRequests = numDisabled + 5 + 6 + numRandom + 3 + 3;
  localparam int cycleLimit  = numRequests * 20 + 200;

  logic        clk;
  logic        rst_n;
  logic        valid_i;
  addr_t       addr_i;
  logic        addr_ok_o;
  logic        data_ok_o;
  word_t       rd_data_o;
  logic        cacheRdValid_o;
  addr_t       cacheAddr_o;
  logic        rdBeat_i;
  logic        rdLast_i;
  word_t       rdData_i;
  logic        csrWrEn_i;
  csrReg_t     csrAddr_i;
  logic [31:0] csrWrData_i;
  logic [31:0] csrRdData_o;

  // reference copy of tags, valid bits and lru bits
  logic [20:0] modelTag [2][64];
  logic        modelValid [2][64];
  logic        modelLru [64];
  logic        modelEn;
  logic [31:0] modelHits;
  logic [31:0] modelMisses;

  addr_t       batchQ[$];
  word_t       expWordQ[$];
  logic        expHitQ[$];
  logic [31:0] lfsrState;
  logic [31:0] regVal;
  addr_t       lineA;
  addr_t       lineB;
  string       curName;
  int          memReads;
  int          cycles;
  int          errors;
  int          checks;
  int          errorsAtStart;
  int          testsRun;
  int          testsFailed;
  int          burstCycles;
  int          i;

  cacheTop dut0 (
    .clk, .rst_n, .valid_i, .addr_i, .addr_ok_o, .data_ok_o, .rd_data_o,
    .cacheRdValid_o, .cacheAddr_o, .rdBeat_i, .rdLast_i, .rdData_i,
    .csrWrEn_i, .csrAddr_i, .csrWrData_i, .csrRdData_o
  );

  always #5 clk = ~clk;

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] lfsrBits(input int n);
    logic [31:0] r;
    logic        b;
    int          k;
    r = '0;
    for (k = 0; k < n; k++) begin
      b = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (b) begin
        lfsrState = lfsrState ^ 32'h8020_0003;
      end
      r = {r[30:0], b};
    end
    return r;
  endfunction

  // four tags over four sets so that ways conflict
  function automatic addr_t randomAddr();
    logic [31:0] tagSel;
    logic [31:0] setSel;
    logic [31:0] low;
    logic [20:0] t;
    logic [5:0]  s;
    tagSel = lfsrBits(2);
    setSel = lfsrBits(2);
    low = lfsrBits(5);
    t = 21'h01000 + 21'(tagSel[1:0]) * 21'h00357;
    s = 6'(setSel[1:0]) * 6'd13;
    return {t, s, low[4:0]};
  endfunction

  // memory word is the aligned address joined with its complement
  function automatic word_t memWord(input addr_t a);
    addr_t aligned;
    aligned = {a[31:3], 3'b000};
    return {aligned, ~aligned};
  endfunction

  function automatic void clearModel();
    int w;
    int s;
    for (s = 0; s < 64; s++) begin
      for (w = 0; w < 2; w++) begin
        modelValid[w][s] = 1'b0;
        modelTag[w][s] = '0;
      end
      modelLru[s] = 1'b0;
    end
  endfunction

  // lru bit names the way to replace next
  function automatic logic predictAccess(input addr_t a);
    logic [20:0] t;
    logic [5:0]  s;
    logic        hit;
    logic        way;
    int          w;
    t = a[31:11];
    s = a[10:5];
    hit = 1'b0;
    way = 1'b0;
    for (w = 0; w < 2; w++) begin
      if (modelEn && modelValid[w][s] && modelTag[w][s] == t) begin
        hit = 1'b1;
        way = w[0];
      end
    end
    if (hit) begin
      modelHits = modelHits + 32'd1;
      modelLru[s] = ~way;
    end else begin
      modelMisses = modelMisses + 32'd1;
      if (modelEn) begin
        way = modelLru[s];
        modelValid[way][s] = 1'b1;
        modelTag[way][s] = t;
        modelLru[s] = ~way;
      end
    end
    return hit;
  endfunction

  task automatic checkWord(input string name, input word_t exp, input word_t act);
    checks = checks + 1;
    if (act !== exp) begin
      errors = errors + 1;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic checkReg(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks = checks + 1;
    if (act !== exp) begin
      errors = errors + 1;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic checkOutcome(input string name, input logic exp, input logic act);
    checks = checks + 1;
    if (act !== exp) begin
      errors = errors + 1;
      $display("ERROR %s: expected %s, actual %s", name,
               exp ? "hit" : "miss", act ? "hit" : "miss");
    end
  endtask

  task automatic writeReg(input csrReg_t a, input logic [31:0] d);
    csrWrEn_i = 1'b1;
    csrAddr_i = a;
    csrWrData_i = d;
    @(negedge clk);
    csrWrEn_i = 1'b0;
    case (a)
      regCtrl: begin
        modelEn = d[0];
        if (d[1]) begin
          clearModel();
          // pulse clears the valid bits one cycle later
          @(negedge clk);
        end
      end
      regHitCount: modelHits = '0;
      regMissCount: modelMisses = '0;
      default: ;
    endcase
  endtask

  task automatic readReg(input csrReg_t a, output logic [31:0] v);
    csrAddr_i = a;
    @(negedge clk);
    v = csrRdData_o;
  endtask

  task automatic checkCounters(input string name);
    logic [31:0] v;
    readReg(regHitCount, v);
    checkReg({name, " hit count"}, modelHits, v);
    readReg(regMissCount, v);
    checkReg({name, " miss count"}, modelMisses, v);
  endtask

  // streams batchQ starting and ending on a falling edge
  task automatic runBatch();
    int   sent;
    int   got;
    int   seenReads;
    logic okNow;
    logic actHit;
    sent = 0;
    got = 0;
    burstCycles = 0;
    seenReads = memReads;
    expWordQ.delete();
    expHitQ.delete();
    while (got < batchQ.size()) begin
      okNow = addr_ok_o;
      if (data_ok_o && got >= sent) begin
        errors = errors + 1;
        $display("%s: data_ok_o rose with no request outstanding", curName);
      end else if (data_ok_o) begin
        // no line read since the last answer means a hit
        actHit = (memReads == seenReads);
        seenReads = memReads;
        checkOutcome(curName, expHitQ[got], actHit);
        checkWord(curName, expWordQ[got], rd_data_o);
        got = got + 1;
      end
      if (sent < batchQ.size()) begin
        valid_i = 1'b1;
        addr_i = batchQ[sent];
        if (okNow) begin
          expHitQ.push_back(predictAccess(batchQ[sent]));
          expWordQ.push_back(memWord(batchQ[sent]));
          sent = sent + 1;
        end
      end else begin
        valid_i = 1'b0;
      end
      burstCycles = burstCycles + 1;
      @(negedge clk);
    end
    valid_i = 1'b0;
  endtask

  // four beats in address order with random gaps
  task automatic serveLine(input addr_t lineAddr);
    logic [31:0] gap;
    int          beat;
    memReads = memReads + 1;
    for (beat = 0; beat < `CACHE_BEATS; beat++) begin
      gap = lfsrBits(2);
      repeat (gap) begin
        @(negedge clk);
        rdBeat_i = 1'b0;
        rdLast_i = 1'b0;
      end
      @(negedge clk);
      rdBeat_i = 1'b1;
      rdLast_i = (beat == `CACHE_BEATS - 1);
      rdData_i = memWord(lineAddr + 32'(beat * 8));
    end
    @(negedge clk);
    rdBeat_i = 1'b0;
    rdLast_i = 1'b0;
  endtask

  task automatic startTest(input string name);
    curName = name;
    errorsAtStart = errors;
    testsRun = testsRun + 1;
  endtask

  task automatic reportTest();
    if (errors == errorsAtStart) begin
      $display("PASS %s", curName);
    end else begin
      testsFailed = testsFailed + 1;
      $display("FAIL %s", curName);
    end
  endtask

  always begin
    @(negedge clk);
    if (rst_n && cacheRdValid_o) begin
      serveLine(cacheAddr_o);
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("timeout after %0d cycles, the cache stopped answering", cycles);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    valid_i = 1'b0;
    addr_i = '0;
    rdBeat_i = 1'b0;
    rdLast_i = 1'b0;
    rdData_i = '0;
    csrWrEn_i = 1'b0;
    csrAddr_i = regCtrl;
    csrWrData_i = '0;
    lfsrState = 32'd3;
    memReads = 0;
    cycles = 0;
    errors = 0;
    checks = 0;
    testsRun = 0;
    testsFailed = 0;
    modelEn = 1'b0;
    modelHits = '0;
    modelMisses = '0;
    clearModel();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    startTest("disabled cache");
    batchQ.delete();
    for (i = 0; i < numDisabled; i++) begin
      batchQ.push_back(randomAddr());
    end
    runBatch();
    checkReg("disabled cache memory reads", 32'(numDisabled), 32'(memReads));
    checkCounters(curName);
    reportTest();

    startTest("hits");
    writeReg(regCtrl, 32'h1);
    lineA = {21'h05A5A, 6'd5, 5'd0};
    batchQ.delete();
    batchQ.push_back(lineA);
    runBatch();
    batchQ.delete();
    for (i = 0; i < 4; i++) begin
      batchQ.push_back(lineA + 32'(i * 8));
    end
    runBatch();
    // one hit per cycle after the first lookup
    checks = checks + 1;
    if (burstCycles != 5) begin
      errors = errors + 1;
      $display("ERROR hits burst cycles: expected 5, actual %0d", burstCycles);
    end
    checkCounters(curName);
    reportTest();

    startTest("replacement");
    batchQ.delete();
    batchQ.push_back({21'h0AAAA, 6'd40, 5'd0});
    batchQ.push_back({21'h0BBBB, 6'd40, 5'd8});
    batchQ.push_back({21'h0AAAA, 6'd40, 5'd16});
    batchQ.push_back({21'h0CCCC, 6'd40, 5'd24});
    batchQ.push_back({21'h0BBBB, 6'd40, 5'd0});
    batchQ.push_back({21'h0AAAA, 6'd40, 5'd8});
    runBatch();
    checkCounters(curName);
    reportTest();

    startTest("varying refill");
    batchQ.delete();
    for (i = 0; i < numRandom; i++) begin
      batchQ.push_back(randomAddr());
    end
    runBatch();
    checkCounters(curName);
    reportTest();

    startTest("invalidate");
    batchQ.delete();
    batchQ.push_back(lineA + 32'd24);
    runBatch();
    writeReg(regCtrl, 32'h3);
    readReg(regCtrl, regVal);
    checkReg("invalidate ctrl", 32'h1, regVal);
    batchQ.delete();
    batchQ.push_back(lineA);
    batchQ.push_back(lineA + 32'd16);
    runBatch();
    checkCounters(curName);
    reportTest();

    startTest("counter clear");
    writeReg(regHitCount, 32'h0);
    writeReg(regMissCount, 32'hFFFF_FFFF);
    checkCounters(curName);
    lineB = {21'h1F00F, 6'd22, 5'd0};
    batchQ.delete();
    batchQ.push_back(lineB);
    batchQ.push_back(lineB);
    batchQ.push_back(lineB + 32'd8);
    runBatch();
    checkCounters(curName);
    reportTest();

    $display("%0d tests, %0d failing, %0d checks, %0d errors",
             testsRun, testsFailed, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+src
src/cacheAddrPkg.sv
src/cacheDataPkg.sv
src/cacheSram.sv
src/cacheLookup.sv
src/cacheRefill.sv
src/cacheCsr.sv
src/cacheTop.sv
bench/cacheTb.sv

/* src/cacheAddrPkg.sv */
`default_nettype none
`include "cache_settings.svh"

package cacheAddrPkg;
  localparam int offsetBits = $clog2(`CACHE_LINE_BYTES);
  localparam int indexBits  = $clog2(`CACHE_SETS);
  localparam int tagBits    = `CACHE_ADDR_WIDTH - indexBits - offsetBits;
  // word number inside a line, byte lanes dropped
  localparam int wordBits   = offsetBits - $clog2(`CACHE_XLEN / 8);

  typedef logic [`CACHE_ADDR_WIDTH-1:0] addr_t;
  typedef logic [tagBits-1:0]           tag_t;
  typedef logic [indexBits-1:0]         index_t;
  typedef logic [offsetBits-1:0]        offset_t;

  function automatic tag_t getTag(addr_t a);
    return a[`CACHE_ADDR_WIDTH-1 -: tagBits];
  endfunction

  function automatic index_t getIndex(addr_t a);
    return a[offsetBits +: indexBits];
  endfunction

  function automatic logic [wordBits-1:0] getWord(addr_t a);
    offset_t off;
    off = a[offsetBits-1:0];
    return off[offsetBits-1 -: wordBits];
  endfunction

  // start address of the line holding a
  function automatic addr_t lineAlign(addr_t a);
    return {a[`CACHE_ADDR_WIDTH-1:offsetBits], {offsetBits{1'b0}}};
  endfunction
endpackage

`default_nettype wire

/* src/cacheCsr.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheCsr (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   csrWrEn_i,
  input  wire cacheDataPkg::csrReg_t  csrAddr_i,
  input  wire logic [31:0]            csrWrData_i,
  output logic [31:0]                 csrRdData_o,
  input  wire logic                   hitPulse_i,
  input  wire logic                   missPulse_i,
  output logic                        cacheEn_o,
  output logic                        invalidate_o
);
  import cacheDataPkg::*;

  logic [31:0] hitCount;
  logic [31:0] missCount;
  logic        ctrlWr;
  logic        hitWr;
  logic        missWr;

  assign ctrlWr = csrWrEn_i && (csrAddr_i == regCtrl);
  assign hitWr  = csrWrEn_i && (csrAddr_i == regHitCount);
  assign missWr = csrWrEn_i && (csrAddr_i == regMissCount);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cacheEn_o    <= 1'b0;
      invalidate_o <= 1'b0;
      hitCount     <= '0;
      missCount    <= '0;
    end else begin
      if (ctrlWr) begin
        cacheEn_o <= csrWrData_i[0];
      end
      // invalidate lasts one cycle, nothing holds it
      invalidate_o <= ctrlWr && csrWrData_i[1];
      // any write clears, counters wrap
      if (hitWr) begin
        hitCount <= '0;
      end else if (hitPulse_i) begin
        hitCount <= hitCount + 1'b1;
      end
      if (missWr) begin
        missCount <= '0;
      end else if (missPulse_i) begin
        missCount <= missCount + 1'b1;
      end
    end
  end

  always_comb begin
    case (csrAddr_i)
      regCtrl:      csrRdData_o = {30'd0, 1'b0, cacheEn_o};
      regHitCount:  csrRdData_o = hitCount;
      regMissCount: csrRdData_o = missCount;
      default:      csrRdData_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* src/cacheDataPkg.sv */
`default_nettype none
`include "cache_settings.svh"

package cacheDataPkg;
  typedef logic [`CACHE_XLEN-1:0] word_t;

  // word 0 sits in the low bits
  typedef word_t [`CACHE_BEATS-1:0] line_t;

  typedef enum logic [2:0] {
    stIdle,
    stCompare,
    stMiss,
    stFill,
    stAnswer
  } lookupState_t;

  // register map of the control block
  typedef enum logic [1:0] {
    regCtrl      = 2'd0,
    regHitCount  = 2'd1,
    regMissCount = 2'd2
  } csrReg_t;
endpackage

`default_nettype wire

/* src/cacheLookup.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module cacheLookup (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  // pipeline side
  input  wire logic                 valid_i,
  input  wire cacheAddrPkg::addr_t  addr_i,
  output logic                      addr_ok_o,
  output logic                      data_ok_o,
  output cacheDataPkg::word_t       rd_data_o,
  // control block
  input  wire logic                 cacheEn_i,
  input  wire logic                 invalidate_i,
  output logic                      hitPulse_o,
  output logic                      missPulse_o,
  // refill engine
  output logic                      fillStart_o,
  output cacheAddrPkg::addr_t       fillAddr_o,
  input  wire logic                 fillDone_i,
  input  wire cacheDataPkg::line_t  fillLine_i,
  // tag and data arrays
  output logic                      tagEn_o,
  output logic [1:0]                tagWr_o,
  output cacheAddrPkg::tag_t        tagWrData_o,
  input  wire cacheAddrPkg::tag_t   tagRd0_i,
  input  wire cacheAddrPkg::tag_t   tagRd1_i,
  output logic                      dataWr0_o,
  output logic                      dataWr1_o,
  output cacheDataPkg::line_t       dataWrData_o,
  input  wire cacheDataPkg::line_t  dataRd0_i,
  input  wire cacheDataPkg::line_t  dataRd1_i,
  output cacheAddrPkg::index_t      arrayAddr_o
);
  import cacheAddrPkg::*;
  import cacheDataPkg::*;

  lookupState_t           state;
  lookupState_t           nextState;
  addr_t                  reqAddr;
  index_t                 reqIndex;
  logic [wordBits-1:0]    reqWord;
  logic [`CACHE_SETS-1:0] validWay0;
  logic [`CACHE_SETS-1:0] validWay1;
  logic [`CACHE_SETS-1:0] lruBits;
  logic                   hit0;
  logic                   hit1;
  logic                   cacheHit;
  logic                   accept;
  logic                   victim;
  logic                   allocate;

  assign reqIndex = getIndex(reqAddr);
  assign reqWord  = getWord(reqAddr);

  // arrays were read with reqIndex in the cycle before compare
  assign hit0 = (state == stCompare) && validWay0[reqIndex] && (tagRd0_i == getTag(reqAddr));
  assign hit1 = (state == stCompare) && validWay1[reqIndex] && (tagRd1_i == getTag(reqAddr));
  // a disabled cache misses on everything
  assign cacheHit = cacheEn_i && (hit0 || hit1);

  assign addr_ok_o = (state == stIdle) || ((state == stCompare) && cacheHit);
  assign accept    = valid_i && addr_ok_o;

  // lru bit names the way to replace next
  assign victim   = lruBits[reqIndex];
  assign allocate = (state == stAnswer) && cacheEn_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= stIdle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      stIdle: begin
        if (valid_i) begin
          nextState = stCompare;
        end
      end
      stCompare: begin
        if (!cacheHit) begin
          nextState = stMiss;
        end else if (!valid_i) begin
          nextState = stIdle;
        end
      end
      stMiss: begin
        nextState = stFill;
      end
      stFill: begin
        if (fillDone_i) begin
          nextState = stAnswer;
        end
      end
      stAnswer: begin
        nextState = stIdle;
      end
      default: begin
        nextState = stIdle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validWay0 <= '0;
      validWay1 <= '0;
      lruBits   <= '0;
    end else if (invalidate_i) begin
      validWay0 <= '0;
      validWay1 <= '0;
      lruBits   <= '0;
    end else if (allocate) begin
      if (victim) begin
        validWay1[reqIndex] <= 1'b1;
      end else begin
        validWay0[reqIndex] <= 1'b1;
      end
      lruBits[reqIndex] <= ~victim;
    end else if (cacheHit) begin
      // the way not used now becomes the victim
      lruBits[reqIndex] <= hit0;
    end
  end

  // index comes from the new request while accepting, else the latched one
  assign arrayAddr_o  = accept ? getIndex(addr_i) : reqIndex;
  assign tagEn_o      = accept || allocate;
  assign tagWr_o      = {allocate && victim, allocate && !victim};
  assign tagWrData_o  = getTag(reqAddr);
  assign dataWr0_o    = allocate && !victim;
  assign dataWr1_o    = allocate && victim;
  assign dataWrData_o = fillLine_i;

  assign hitPulse_o  = cacheHit;
  assign missPulse_o = (state == stCompare) && !cacheHit;
  assign fillStart_o = (state == stMiss);
  assign fillAddr_o  = reqAddr;

  assign data_ok_o = cacheHit || (state == stAnswer);

  always_comb begin
    if (state == stAnswer) begin
      rd_data_o = fillLine_i[reqWord];
    end else if (hit1) begin
      rd_data_o = dataRd1_i[reqWord];
    end else begin
      rd_data_o = dataRd0_i[reqWord];
    end
  end

  // a line never lives in both ways
  singleWayHit: assert property (@(posedge clk) disable iff (!rst_n)
    !(hit0 && hit1));

endmodule

`default_nettype wire

/* src/cacheRefill.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module cacheRefill (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 fillStart_i,
  input  wire cacheAddrPkg::addr_t  fillAddr_i,
  output logic                      cacheRdValid_o,
  output cacheAddrPkg::addr_t       cacheAddr_o,
  input  wire logic                 rdBeat_i,
  input  wire logic                 rdLast_i,
  input  wire cacheDataPkg::word_t  rdData_i,
  output logic                      fillDone_o,
  output cacheDataPkg::line_t       fillLine_o
);
  import cacheAddrPkg::*;

  logic                busy;
  logic [wordBits-1:0] beatCnt;
  addr_t               lineAddr;

  // read request goes out in the same cycle as fillStart
  assign cacheRdValid_o = fillStart_i;
  assign cacheAddr_o    = fillStart_i ? lineAlign(fillAddr_i) : lineAddr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      beatCnt    <= '0;
      fillDone_o <= 1'b0;
    end else begin
      fillDone_o <= rdBeat_i && rdLast_i;
      if (fillStart_i) begin
        busy    <= 1'b1;
        beatCnt <= '0;
      end else if (rdBeat_i) begin
        beatCnt <= beatCnt + 1'b1;
        if (rdLast_i) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // beats arrive in address order
  always_ff @(posedge clk) begin
    if (fillStart_i) begin
      lineAddr <= lineAlign(fillAddr_i);
    end
    if (rdBeat_i) begin
      fillLine_o[beatCnt] <= rdData_i;
    end
  end

  noIdleBeat: assert property (@(posedge clk) disable iff (!rst_n)
    rdBeat_i |-> busy);

  lastOnFourth: assert property (@(posedge clk) disable iff (!rst_n)
    rdLast_i |-> rdBeat_i && (beatCnt == wordBits'(`CACHE_BEATS - 1)));

endmodule

`default_nettype wire

/* src/cacheSram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module cacheSram #(
  parameter type payload_t = logic,
  parameter int  depth     = `CACHE_SETS
) (
  input  wire logic                 clk,
  input  wire logic                 en_i,
  input  wire logic                 wrEn_i,
  input  wire cacheAddrPkg::index_t addr_i,
  input  wire payload_t             wrData_i,
  output payload_t                  rdData_o
);

  payload_t mem [depth];

  // read returns the old contents on a write cycle
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (wrEn_i) begin
        mem[addr_i] <= wrData_i;
      end
      rdData_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

/* src/cacheTop.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module cacheTop (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  // pipeline side
  input  wire logic                   valid_i,
  input  wire cacheAddrPkg::addr_t    addr_i,
  output logic                        addr_ok_o,
  output logic                        data_ok_o,
  output cacheDataPkg::word_t         rd_data_o,
  // memory side
  output logic                        cacheRdValid_o,
  output cacheAddrPkg::addr_t         cacheAddr_o,
  input  wire logic                   rdBeat_i,
  input  wire logic                   rdLast_i,
  input  wire cacheDataPkg::word_t    rdData_i,
  // register side
  input  wire logic                   csrWrEn_i,
  input  wire cacheDataPkg::csrReg_t  csrAddr_i,
  input  wire logic [31:0]            csrWrData_i,
  output logic [31:0]                 csrRdData_o
);
  import cacheAddrPkg::*;
  import cacheDataPkg::*;

  logic       cacheEn;
  logic       invalidate;
  logic       hitPulse;
  logic       missPulse;
  logic       fillStart;
  addr_t      fillAddr;
  logic       fillDone;
  line_t      fillLine;
  logic       tagEn;
  logic [1:0] tagWr;
  tag_t       tagWrData;
  tag_t       tagRd0;
  tag_t       tagRd1;
  logic       dataWr0;
  logic       dataWr1;
  line_t      dataWrData;
  line_t      dataRd0;
  line_t      dataRd1;
  index_t     arrayAddr;

  cacheLookup lookup0 (
    .clk, .rst_n, .valid_i, .addr_i, .addr_ok_o, .data_ok_o, .rd_data_o,
    .cacheEn_i(cacheEn), .invalidate_i(invalidate),
    .hitPulse_o(hitPulse), .missPulse_o(missPulse),
    .fillStart_o(fillStart), .fillAddr_o(fillAddr),
    .fillDone_i(fillDone), .fillLine_i(fillLine),
    .tagEn_o(tagEn), .tagWr_o(tagWr), .tagWrData_o(tagWrData),
    .tagRd0_i(tagRd0), .tagRd1_i(tagRd1),
    .dataWr0_o(dataWr0), .dataWr1_o(dataWr1), .dataWrData_o(dataWrData),
    .dataRd0_i(dataRd0), .dataRd1_i(dataRd1), .arrayAddr_o(arrayAddr)
  );

  cacheRefill refill0 (
    .clk, .rst_n, .fillStart_i(fillStart), .fillAddr_i(fillAddr),
    .cacheRdValid_o, .cacheAddr_o, .rdBeat_i, .rdLast_i, .rdData_i,
    .fillDone_o(fillDone), .fillLine_o(fillLine)
  );

  cacheCsr csr0 (
    .clk, .rst_n, .csrWrEn_i, .csrAddr_i, .csrWrData_i, .csrRdData_o,
    .hitPulse_i(hitPulse), .missPulse_i(missPulse),
    .cacheEn_o(cacheEn), .invalidate_o(invalidate)
  );

  // two ways, tags and lines in separate arrays
  cacheSram #(.payload_t(tag_t), .depth(`CACHE_SETS)) tagWay0 (
    .clk, .en_i(tagEn), .wrEn_i(tagWr[0]), .addr_i(arrayAddr),
    .wrData_i(tagWrData), .rdData_o(tagRd0)
  );
  cacheSram #(.payload_t(tag_t), .depth(`CACHE_SETS)) tagWay1 (
    .clk, .en_i(tagEn), .wrEn_i(tagWr[1]), .addr_i(arrayAddr),
    .wrData_i(tagWrData), .rdData_o(tagRd1)
  );
  cacheSram #(.payload_t(line_t), .depth(`CACHE_SETS)) dataWay0 (
    .clk, .en_i(tagEn), .wrEn_i(dataWr0), .addr_i(arrayAddr),
    .wrData_i(dataWrData), .rdData_o(dataRd0)
  );
  cacheSram #(.payload_t(line_t), .depth(`CACHE_SETS)) dataWay1 (
    .clk, .en_i(tagEn), .wrEn_i(dataWr1), .addr_i(arrayAddr),
    .wrData_i(dataWrData), .rdData_o(dataRd1)
  );

endmodule

`default_nettype wire

/* src/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// request address width
`define CACHE_ADDR_WIDTH 32

// one data word, also one refill beat
`define CACHE_XLEN 64

// cache geometry
`define CACHE_SETS 64
`define CACHE_LINE_BYTES 32

// memory beats needed to fill one line
`define CACHE_BEATS 4

`endif
